// File: src/core_pkg.sv
// shared widths, credit depths, op codes and packed bus structs for the execution back end
`default_nettype none

package core_pkg;

    localparam int XLEN        = 32; // data path width
    localparam int REG_ADDR_W  = 5;  // x0..x31
    localparam int COMMIT_ID_W = 3;  // ids wrap mod 8
    localparam int ALU_CREDITS = 2;  // alu result queue depth
    localparam int MD_CREDITS  = 1;  // muldiv holds one op
    localparam int CREDIT_W    = 2;  // wide enough for the larger depth

    // top bit set means multiply/divide class
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLL   = 4'h5,
        OP_SRL   = 4'h6,
        OP_SLT   = 4'h7, // signed compare
        OP_MUL   = 4'h8, // low word
        OP_MULHU = 4'h9, // unsigned high word
        OP_DIVU  = 4'ha,
        OP_REMU  = 4'hb
    } op_e;

    // instruction as it enters, operands already read
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
    } instr_t;

    // decoder to unit
    typedef struct packed {
        op_e                    op;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic [COMMIT_ID_W-1:0] commit_id;
    } exu_req_t;

    // unit result toward writeback
    typedef struct packed {
        logic                   valid;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        wdata;
        logic [COMMIT_ID_W-1:0] commit_id;
    } wb_req_t;

    // register file write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: src/idu.sv
// decoder: splits ops by class, stamps commit ids and issues to alu or muldiv under credit control
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  logic              clk,
    input  logic              rst_n_i,

    // incoming instruction handshake
    input  logic              instr_valid_i,
    input  core_pkg::instr_t  instr_i,
    output logic              instr_ready_o,

    // issue strobes, one shared request bus
    output logic              alu_issue_o,
    output logic              md_issue_o,
    output core_pkg::exu_req_t issue_req_o,

    // credit returns from the units
    input  logic              alu_credit_i,
    input  logic              md_credit_i
);

    logic                             is_md;     // muldiv class
    logic                             accept;
    logic [core_pkg::CREDIT_W-1:0]    alu_cnt_q; // free alu queue slots
    logic [core_pkg::CREDIT_W-1:0]    md_cnt_q;  // free muldiv slots
    logic [core_pkg::COMMIT_ID_W-1:0] cid_q;     // next commit id

    assign is_md = instr_i.op[3]; // top op bit picks the class

    // ready follows the credit of the offered op's unit
    assign instr_ready_o = is_md ? (md_cnt_q != '0) : (alu_cnt_q != '0);
    assign accept        = instr_valid_i && instr_ready_o;

    assign alu_issue_o = accept && !is_md;
    assign md_issue_o  = accept && is_md;

    // request goes out in the cycle of acceptance
    always_comb begin
        issue_req_o.op        = instr_i.op;
        issue_req_o.rd        = instr_i.rd;
        issue_req_o.a         = instr_i.a;
        issue_req_o.b         = instr_i.b;
        issue_req_o.commit_id = cid_q;
    end

    // credit counters, issue and return may coincide
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_cnt_q <= core_pkg::CREDIT_W'(core_pkg::ALU_CREDITS); // full after reset
            md_cnt_q  <= core_pkg::CREDIT_W'(core_pkg::MD_CREDITS);
        end else begin
            alu_cnt_q <= alu_cnt_q
                         + core_pkg::CREDIT_W'(alu_credit_i)
                         - core_pkg::CREDIT_W'(alu_issue_o);
            md_cnt_q  <= md_cnt_q
                         + core_pkg::CREDIT_W'(md_credit_i)
                         - core_pkg::CREDIT_W'(md_issue_o);
        end
    end

    // commit id wraps naturally
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cid_q <= '0;
        end else if (accept) begin
            cid_q <= cid_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/alu.sv
// single-cycle alu with a two-entry in-order result queue toward writeback
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               issue_i,
    input  core_pkg::exu_req_t req_i,
    output core_pkg::wb_req_t  res_o,
    input  logic               ready_i,  // from wbu
    output logic               credit_o  // slot freed
);

    logic [core_pkg::XLEN-1:0]     alu_res;
    logic                          slt_bit;
    logic                          pop;
    core_pkg::wb_req_t             q_q [core_pkg::ALU_CREDITS]; // payload, no reset
    logic                          wr_ptr_q;
    logic                          rd_ptr_q;
    logic [core_pkg::CREDIT_W-1:0] cnt_q;    // entries held

    assign slt_bit = $signed(req_i.a) < $signed(req_i.b);

    always_comb begin
        case (req_i.op)
            core_pkg::OP_ADD: alu_res = req_i.a + req_i.b;
            core_pkg::OP_SUB: alu_res = req_i.a - req_i.b;
            core_pkg::OP_AND: alu_res = req_i.a & req_i.b;
            core_pkg::OP_OR:  alu_res = req_i.a | req_i.b;
            core_pkg::OP_XOR: alu_res = req_i.a ^ req_i.b;
            core_pkg::OP_SLL: alu_res = req_i.a << req_i.b[4:0]; // low 5 bits only
            core_pkg::OP_SRL: alu_res = req_i.a >> req_i.b[4:0];
            core_pkg::OP_SLT: alu_res = {{(core_pkg::XLEN-1){1'b0}}, slt_bit};
            default:          alu_res = '0; // muldiv ops never reach here
        endcase
    end

    // head of queue, valid from occupancy
    always_comb begin
        res_o       = q_q[rd_ptr_q];
        res_o.valid = (cnt_q != '0);
    end

    assign pop      = res_o.valid && ready_i;
    assign credit_o = pop; // one credit per pop

    always_ff @(posedge clk) begin
        if (issue_i) begin
            q_q[wr_ptr_q] <= '{valid: 1'b1, rd: req_i.rd, wdata: alu_res,
                               commit_id: req_i.commit_id};
        end
    end

    // pointers and count, push and pop may coincide
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (issue_i) wr_ptr_q <= ~wr_ptr_q;
            if (pop)     rd_ptr_q <= ~rd_ptr_q;
            cnt_q <= cnt_q + core_pkg::CREDIT_W'(issue_i) - core_pkg::CREDIT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// File: src/muldiv.sv
// multiply/divide unit: three-cycle registered multiply and 32-step restoring divide, one op at a time
`timescale 1ns/1ps
`default_nettype none

module muldiv (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               issue_i,
    input  core_pkg::exu_req_t req_i,
    output core_pkg::wb_req_t  res_o,
    input  logic               ready_i,
    output logic               credit_o
);

    typedef enum logic [1:0] {S_IDLE, S_MUL, S_DIV, S_DONE} md_state_e;

    md_state_e                        state_q;
    logic [4:0]                       step_q;    // mul stage or div step
    core_pkg::op_e                    op_q;
    logic [core_pkg::REG_ADDR_W-1:0]  rd_q;
    logic [core_pkg::COMMIT_ID_W-1:0] cid_q;
    logic [core_pkg::XLEN-1:0]        a_q;       // multiplicand, or dividend shifting into quotient
    logic [core_pkg::XLEN-1:0]        b_q;       // multiplier or divisor
    logic [core_pkg::XLEN-1:0]        rem_q;     // partial remainder
    logic [2*core_pkg::XLEN-1:0]      prod_q;    // full product
    logic [core_pkg::XLEN-1:0]        wdata_q;
    logic [core_pkg::XLEN:0]          shift_w;   // remainder with next dividend bit
    logic [core_pkg::XLEN:0]          trial_w;   // trial subtract, top bit is borrow
    logic [core_pkg::XLEN-1:0]        rem_nxt;
    logic [core_pkg::XLEN-1:0]        quo_nxt;

    // one restoring step, b = 0 leaves all ones and the dividend as remainder
    assign shift_w = {rem_q, a_q[core_pkg::XLEN-1]};
    assign trial_w = shift_w - {1'b0, b_q};
    assign rem_nxt = trial_w[core_pkg::XLEN] ? shift_w[core_pkg::XLEN-1:0]
                                             : trial_w[core_pkg::XLEN-1:0];
    assign quo_nxt = {a_q[core_pkg::XLEN-2:0], ~trial_w[core_pkg::XLEN]};

    always_comb begin
        res_o.valid     = (state_q == S_DONE);
        res_o.rd        = rd_q;
        res_o.wdata     = wdata_q;
        res_o.commit_id = cid_q;
    end

    assign credit_o = res_o.valid && ready_i; // consumed by wbu

    // datapath, no reset
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && issue_i) begin
            op_q  <= req_i.op;
            rd_q  <= req_i.rd;
            cid_q <= req_i.commit_id;
            a_q   <= req_i.a;
            b_q   <= req_i.b;
            rem_q <= '0;
        end else if (state_q == S_MUL) begin
            if (step_q == 5'd0) begin
                prod_q <= {{core_pkg::XLEN{1'b0}}, a_q} * {{core_pkg::XLEN{1'b0}}, b_q};
            end else begin // stage 3, pick the word
                wdata_q <= (op_q == core_pkg::OP_MULHU) ? prod_q[2*core_pkg::XLEN-1:core_pkg::XLEN]
                                                        : prod_q[core_pkg::XLEN-1:0];
            end
        end else if (state_q == S_DIV) begin
            rem_q <= rem_nxt;
            a_q   <= quo_nxt;
            if (step_q == 5'd31) wdata_q <= (op_q == core_pkg::OP_REMU) ? rem_nxt : quo_nxt;
        end
    end

    // control
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (issue_i) begin
                    step_q  <= '0;
                    state_q <= (req_i.op == core_pkg::OP_DIVU || req_i.op == core_pkg::OP_REMU)
                               ? S_DIV : S_MUL;
                end
                S_MUL: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd1) state_q <= S_DONE; // valid 3 cycles after accept
                end
                S_DIV: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == 5'd31) state_q <= S_DONE; // 32 steps done
                end
                default: if (ready_i) state_q <= S_IDLE; // hold until taken
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/wbu.sv
// writeback arbiter: fixed priority muldiv over alu, drives register write and commit report
`timescale 1ns/1ps
`default_nettype none

module wbu (
    input  core_pkg::wb_req_t                alu_res_i,
    input  core_pkg::wb_req_t                md_res_i,
    output logic                             alu_ready_o,
    output logic                             md_ready_o,
    input  logic                             int_assert_i,   // kills write and commit
    output core_pkg::reg_wr_t                reg_wr_o,
    output logic                             commit_valid_o,
    output logic [core_pkg::COMMIT_ID_W-1:0] commit_id_o
);

    logic md_active;
    logic alu_active;
    logic alu_conflict; // alu loses to muldiv
    logic md_en;
    logic alu_en;
    logic any_en;
    logic wb_ok;        // no interrupt pending

    assign md_active  = md_res_i.valid;
    assign alu_active = alu_res_i.valid;

    assign alu_conflict = md_active && alu_active;

    // muldiv always wins, alu waits on a clash
    assign md_ready_o  = 1'b1;
    assign alu_ready_o = !alu_conflict;

    assign md_en  = md_active;
    assign alu_en = alu_active && !alu_conflict;
    assign any_en = md_en || alu_en;

    // results still drain under interrupt, just discarded
    assign wb_ok = !int_assert_i;

    assign reg_wr_o.we = any_en && wb_ok;

    // and-or select, grants are one-hot
    assign reg_wr_o.waddr = ({core_pkg::REG_ADDR_W{md_en}}  & md_res_i.rd)
                          | ({core_pkg::REG_ADDR_W{alu_en}} & alu_res_i.rd);
    assign reg_wr_o.wdata = ({core_pkg::XLEN{md_en}}  & md_res_i.wdata)
                          | ({core_pkg::XLEN{alu_en}} & alu_res_i.wdata);

    // commit report, x0 writes still commit
    assign commit_valid_o = any_en && wb_ok;
    assign commit_id_o    = ({core_pkg::COMMIT_ID_W{md_en}}  & md_res_i.commit_id)
                          | ({core_pkg::COMMIT_ID_W{alu_en}} & alu_res_i.commit_id);

endmodule

`default_nettype wire

// File: src/regfile.sv
// 32-entry integer register file with x0 tied to zero and a combinational debug read port
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  core_pkg::reg_wr_t               wr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] dbg_raddr_i,
    output logic [core_pkg::XLEN-1:0]       dbg_rdata_o
);

    logic [core_pkg::XLEN-1:0] regs_q [32]; // x0..x31

    // writes to x0 dropped
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.we && wr_i.waddr != '0) begin
            regs_q[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // x0 reads zero regardless
    assign dbg_rdata_o = (dbg_raddr_i == '0) ? '0 : regs_q[dbg_raddr_i];

endmodule

`default_nettype wire

// File: src/exu_top.sv
// back end top: decoder, alu, muldiv, writeback and register file wired together
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             instr_valid_i,
    input  core_pkg::instr_t                 instr_i,
    output logic                             instr_ready_o,
    input  logic                             int_assert_i,
    output logic                             commit_valid_o,
    output logic [core_pkg::COMMIT_ID_W-1:0] commit_id_o,
    output core_pkg::reg_wr_t                reg_wr_o,   // observed copy of the write port
    input  logic [core_pkg::REG_ADDR_W-1:0]  dbg_raddr_i,
    output logic [core_pkg::XLEN-1:0]        dbg_rdata_o
);

    logic               alu_issue;
    logic               md_issue;
    core_pkg::exu_req_t issue_req;  // shared by both units
    logic               alu_credit;
    logic               md_credit;
    core_pkg::wb_req_t  alu_res;
    core_pkg::wb_req_t  md_res;
    logic               alu_ready;
    logic               md_ready;
    core_pkg::reg_wr_t  reg_wr;

    idu u_idu (
        .clk, .rst_n_i, .instr_valid_i, .instr_i, .instr_ready_o,
        .alu_issue_o (alu_issue), .md_issue_o (md_issue), .issue_req_o (issue_req),
        .alu_credit_i(alu_credit), .md_credit_i(md_credit)
    );

    alu u_alu (
        .clk, .rst_n_i, .issue_i(alu_issue), .req_i(issue_req),
        .res_o(alu_res), .ready_i(alu_ready), .credit_o(alu_credit)
    );

    muldiv u_muldiv (
        .clk, .rst_n_i, .issue_i(md_issue), .req_i(issue_req),
        .res_o(md_res), .ready_i(md_ready), .credit_o(md_credit)
    );

    wbu u_wbu (
        .alu_res_i(alu_res), .md_res_i(md_res),
        .alu_ready_o(alu_ready), .md_ready_o(md_ready),
        .int_assert_i, .reg_wr_o(reg_wr), .commit_valid_o, .commit_id_o
    );

    regfile u_regfile (
        .clk, .rst_n_i, .wr_i(reg_wr), .dbg_raddr_i, .dbg_rdata_o
    );

    assign reg_wr_o = reg_wr;

endmodule

`default_nettype wire

// File: sim/wbu_chk.sv
// writeback assertions bound into exu_top where the wbu ports meet a clock
`timescale 1ns/1ps
`default_nettype none

module wbu_chk (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              alu_valid_i,
    input  logic              md_valid_i,
    input  logic              alu_ready_i,
    input  logic              md_ready_i,
    input  logic              int_assert_i,
    input  core_pkg::reg_wr_t reg_wr_i,
    input  logic              commit_valid_i
);

    // at most one unit stalls and alu only on a clash
    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        (alu_ready_i || md_ready_i) && (alu_ready_i || (alu_valid_i && md_valid_i)))
        else $error("writeback ready low outside a clash");

    // interrupt kills write and commit
    a_int_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        int_assert_i |-> (!reg_wr_i.we && !commit_valid_i))
        else $error("write or commit while interrupt asserted");

    a_we_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_i.we |-> commit_valid_i)
        else $error("register write without commit");

endmodule

bind exu_top wbu_chk u_wbu_chk (
    .clk(clk), .rst_n_i(rst_n_i), .alu_valid_i(alu_res.valid), .md_valid_i(md_res.valid),
    .alu_ready_i(alu_ready), .md_ready_i(md_ready),
    .int_assert_i(int_assert_i), .reg_wr_i(reg_wr), .commit_valid_i(commit_valid_o)
);

`default_nettype wire

// File: sim/tb_top.sv
// exu_top testbench that replays sim/wb_tests.txt and then a divide against back-to-back alu ops
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    logic                      clk;
    logic                      rst_n_i;
    logic                      instr_valid_i;
    core_pkg::instr_t          instr_i;
    logic                      instr_ready_o;
    logic                      int_assert_i;
    logic                      commit_valid_o;
    logic [2:0]                commit_id_o;
    core_pkg::reg_wr_t         reg_wr_o;
    logic [4:0]                dbg_raddr_i;
    logic [31:0]               dbg_rdata_o;

    logic [111:0] tests_mem [64];  // op, rd, a, b, int, expected
    logic [31:0]  model_regs [32]; // shadow register file
    logic [2:0]   cq_id [$];       // commits seen
    logic [4:0]   cq_addr [$];
    logic [31:0]  cq_data [$];
    logic         cq_we [$];
    logic [2:0]   clash_md [$];    // ids valid together at wbu
    logic [2:0]   clash_alu [$];
    logic [31:0]  exp_by_id [8];
    logic [4:0]   rd_by_id [8];
    logic         seen [8];
    logic [2:0]   next_id;         // expected commit id of next accept
    logic [31:0]  rng;
    int           errors;
    int           passed;
    int           failed;

    exu_top DUT (.*);

    always #4 clk = ~clk;

    // sample outputs 2 ns after the falling edge once inputs have settled
    always @(negedge clk) begin
        #2;
        if (rst_n_i) begin
            if (commit_valid_o) begin
                cq_id.push_back(commit_id_o);
                cq_addr.push_back(reg_wr_o.waddr);
                cq_data.push_back(reg_wr_o.wdata);
                cq_we.push_back(reg_wr_o.we);
            end
            if (DUT.alu_res.valid && DUT.md_res.valid) begin
                clash_md.push_back(DUT.md_res.commit_id);
                clash_alu.push_back(DUT.alu_res.commit_id);
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference results straight from the op definitions
    function automatic logic [31:0] compute_result(input logic [3:0] op,
                                                   input logic [31:0] a, b);
        logic [63:0] p;
        p = {32'd0, a} * {32'd0, b};
        case (op)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return a & b;
            4'h3: return a | b;
            4'h4: return a ^ b;
            4'h5: return a << b[4:0];
            4'h6: return a >> b[4:0];
            4'h7: return {31'd0, $signed(a) < $signed(b)};
            4'h8: return p[31:0];
            4'h9: return p[63:32];
            4'ha: return (b == 0) ? 32'hffff_ffff : a / b; // riscv div by zero
            4'hb: return (b == 0) ? a : a % b;
            default: return 32'hdead_beef;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // drive on the falling edge and hold until the accepting edge
    task automatic issue(input logic [3:0] op, input logic [4:0] rd,
                         input logic [31:0] a, b, input logic intf);
        int t;
        t = 0;
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = '{op: core_pkg::op_e'(op), rd: rd, a: a, b: b};
        int_assert_i  = intf;
        #1;
        while (!instr_ready_o && t < 200) begin
            @(negedge clk);
            #1;
            t++;
        end
        if (!instr_ready_o) begin
            $display("timeout: instruction op %h was never accepted", op);
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic idle();
        @(negedge clk);
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_commit();
        int t;
        t = 0;
        while (cq_id.size() == 0 && t < 200) begin
            @(negedge clk);
            #3; // after the monitor
            t++;
        end
        if (cq_id.size() == 0) begin
            $display("timeout: expected commit never arrived");
            errors++;
        end
    endtask

    task automatic read_reg(input logic [4:0] rd, output logic [31:0] val);
        @(negedge clk);
        dbg_raddr_i = rd;
        #1;
        val = dbg_rdata_o;
    endtask

    initial begin
        logic [3:0]  op;
        logic [4:0]  rd;
        logic [31:0] a, b, expv, val;
        logic        intf;
        logic [2:0]  id, div_id;
        logic [2:0]  alu_ids [4];
        int          i, err0, alu_n, ntest;

        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        int_assert_i  = 1'b0;
        instr_i       = '0;
        dbg_raddr_i   = '0;
        errors        = 0;
        passed        = 0;
        failed        = 0;
        next_id       = '0;
        rng = 32'h1cd3_d24b;
        for (i = 0; i < 32; i++) model_regs[i] = '0;
        for (i = 0; i < 64; i++) tests_mem[i] = {4'hf, 102'd0, 6'(i)}; // end marker op
        $readmemh("sim/wb_tests.txt", tests_mem);
        repeat (10) @(posedge clk);
        @(negedge clk) rst_n_i = 1'b1;

        ntest = 0;
        for (i = 0; i < 64 && tests_mem[i][111:108] != 4'hf; i++) begin
            {op, rd} = {tests_mem[i][111:108], tests_mem[i][104:100]};
            {a, b}   = tests_mem[i][99:36];
            intf     = tests_mem[i][32];
            expv     = tests_mem[i][31:0];
            rng      = xorshift32(rng);
            repeat (rng % 4) @(negedge clk); // random idle gap
            err0 = errors;
            check_eq(expv, compute_result(op, a, b), "table entry");
            issue(op, rd, a, b, intf);
            idle();
            id = next_id;
            next_id++;
            if (intf) begin
                repeat (40) @(negedge clk); // longer than a divide
                int_assert_i = 1'b0;
                #3;
                check_eq(32'(cq_id.size()), 0, "commit under interrupt");
            end else begin
                wait_commit();
                if (cq_id.size() != 0) begin
                    check_eq(cq_id.pop_front(), id, "commit id");
                    check_eq(cq_addr.pop_front(), rd, "write address");
                    check_eq(cq_data.pop_front(), expv, "write data");
                    check_eq(cq_we.pop_front(), 1'b1, "write enable");
                    if (rd != 0) model_regs[rd] = expv;
                end
            end
            read_reg(rd, val);
            check_eq(val, model_regs[rd], "register readback");
            check_eq(32'(cq_id.size()), 0, "extra commits");
            $display("test %0d op %h rd %0d: %s", i, op, rd, (errors == err0) ? "ok" : "FAIL");
            if (errors == err0) begin
                passed++;
            end else begin
                failed++;
            end
            ntest++;
        end

        // divide in flight with credit checks and alu ops landing on its final cycles
        err0 = errors;
        for (i = 0; i < 8; i++) seen[i] = 1'b0;
        issue(4'ha, 5'd20, 32'd1000, 32'd7, 1'b0);
        div_id = next_id;
        next_id++;
        exp_by_id[div_id] = compute_result(4'ha, 32'd1000, 32'd7);
        rd_by_id[div_id]  = 5'd20;
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i.op    = core_pkg::OP_MUL;
        #1 check_eq(instr_ready_o, 1'b0, "ready for muldiv op during divide");
        @(negedge clk);
        instr_i.op    = core_pkg::OP_ADD;
        #1 check_eq(instr_ready_o, 1'b1, "ready for alu op during divide");
        repeat (27) @(negedge clk);
        for (i = 0; i < 4; i++) begin
            issue(4'h0, 5'(21 + i), 32'(i), 32'd100, 1'b0);
            alu_ids[i]           = next_id;
            exp_by_id[next_id]   = compute_result(4'h0, 32'(i), 32'd100);
            rd_by_id[next_id]    = 5'(21 + i);
            next_id++;
        end
        idle();
        alu_n = 0;
        repeat (5) begin
            wait_commit();
            if (cq_id.size() != 0) begin
                id = cq_id.pop_front();
                if (seen[id]) begin
                    $display("commit id %0d was reported twice", id);
                    errors++;
                end
                seen[id] = 1'b1;
                check_eq(cq_addr.pop_front(), rd_by_id[id], "write address");
                check_eq(cq_data.pop_front(), exp_by_id[id], "write data");
                check_eq(cq_we.pop_front(), 1'b1, "write enable");
                model_regs[rd_by_id[id]] = exp_by_id[id];
                if (id != div_id) begin
                    check_eq(id, alu_ids[alu_n], "alu commit order");
                    alu_n++;
                end
                foreach (clash_alu[k]) begin
                    if (clash_alu[k] == id && !seen[clash_md[k]]) begin
                        $display("alu commit %0d came before muldiv commit %0d", id, clash_md[k]);
                        errors++;
                    end
                end
            end
        end
        if (clash_alu.size() == 0) begin
            $display("alu and muldiv results were never valid together");
            errors++;
        end
        @(negedge clk);
        instr_i.op = core_pkg::OP_MUL;
        #1 check_eq(instr_ready_o, 1'b1, "ready for muldiv op after divide");
        read_reg(5'd20, val);
        check_eq(val, model_regs[20], "divide readback");
        check_eq(32'(cq_id.size()), 0, "extra commits");
        $display("test %0d divide with back-to-back alu: %s", ntest,
                 (errors == err0) ? "ok" : "FAIL");
        if (errors == err0) begin
            passed++;
        end else begin
            failed++;
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 ntest + 1, passed, failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/wb_tests.txt
// columns: op(4b) _ rd(8b) _ a(32b) _ b(32b) _ int flag(4b) _ expected wdata(32b)
// op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt 8 mul 9 mulhu a divu b remu
0_01_00000005_00000003_0_00000008
1_02_00000003_00000005_0_fffffffe
2_03_f0f0ff00_0ff0f0f0_0_00f0f000
3_04_f0f0ff00_0ff0f0f0_0_fff0fff0
4_05_f0f0ff00_0ff0f0f0_0_ff000ff0
5_06_00000001_00000024_0_00000010
6_07_80000000_0000003f_0_00000001
7_08_ffffffff_00000001_0_00000001
7_09_00000005_ffffffff_0_00000000
8_0a_12345678_00000010_0_23456780
9_0b_ffffffff_ffffffff_0_fffffffe
a_0c_00000064_00000007_0_0000000e
b_0d_00000064_00000007_0_00000002
a_0e_00001234_00000000_0_ffffffff
b_0f_00001234_00000000_0_00001234
// interrupt held, registers keep old values
0_01_00000001_00000001_1_00000002
8_02_00000007_00000006_1_0000002a
a_03_00000064_00000007_1_0000000e
// x0 commits but stays zero
0_00_00000005_00000006_0_0000000b
0_10_7fffffff_00000001_0_80000000
8_11_0000ffff_0000ffff_0_fffe0001

// File: sim.f
src/core_pkg.sv
src/idu.sv
src/alu.sv
src/muldiv.sv
src/wbu.sv
src/regfile.sv
src/exu_top.sv
sim/wbu_chk.sv
sim/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sim.f

out="$(./obj_dir/Vtb_top)"
echo "$out"

if grep -q "All tests passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
